// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbMacCell
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/mac_consts.svh
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
+incdir+include
rtl/mac_pkg.sv
rtl/mac_ifs.sv
rtl/cmd_decode.sv
rtl/fp8_multiply.sv
rtl/fp16_add.sv
rtl/mac_execute.sv
rtl/acc_result.sv
rtl/mac_cell_top.sv
sim/tb_mac_cell.sv

// ==== include/mac_consts.svh ====
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

// Accumulator file size and index width
`define MAC_ACC_COUNT   4
`define MAC_ACC_BITS    2

// Command queue depth, equal to the sender's starting credits
`define MAC_CMD_DEPTH   4

// Result credits held by the cell after reset
`define MAC_RES_CREDITS 2

// Float field widths
`define FP8_EXP_BITS    5
`define FP8_MAN_BITS    2
`define FP16_EXP_BITS   5
`define FP16_MAN_BITS   10

// Both formats share one bias
`define FP_EXP_BIAS     15
`define FP_EXP_MAX      31

`endif

// ==== rtl/acc_result.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mac_consts.svh"

module accResult (
    input  logic             clk,
    input  logic             rst_n,
    input  mac_pkg::accIdx_t accSel,
    output mac_pkg::fp16_t   accValue,
    output logic             resValid,
    output mac_pkg::fp16_t   resData,
    wbIf.sink                wb
);
    import mac_pkg::*;

    fp16_t accMem [`MAC_ACC_COUNT];
    logic  accWrite;

    // LOAD and MAC write back, READ only reports
    assign accWrite = wb.valid && (wb.op != READ);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MAC_ACC_COUNT; i++) begin
                accMem[i] <= '0;
            end
        end else if (accWrite) begin
            accMem[wb.acc] <= wb.value;
        end
    end

    // Combinational read for the execute stage
    assign accValue = accMem[accSel];

    // Result port follows the registered writeback, one cycle per READ
    assign resValid = wb.valid && (wb.op == READ);
    assign resData  = wb.value;

endmodule

`default_nettype wire

// ==== rtl/cmd_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mac_consts.svh"

module cmdDecode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmdValid,
    input  mac_pkg::macOp_e   cmdOp,
    input  mac_pkg::accIdx_t  cmdAcc,
    input  mac_pkg::cmdData_u cmdData,
    input  logic              resCredit,
    output logic              cmdCredit,
    issueIf.issue             issue,
    wbIf.monitor              wb
);
    import mac_pkg::*;

    localparam int PtrW  = $clog2(`MAC_CMD_DEPTH);
    localparam int CredW = $clog2(`MAC_RES_CREDITS + 1);

    macOp_e   qOp   [`MAC_CMD_DEPTH];
    accIdx_t  qAcc  [`MAC_CMD_DEPTH];
    cmdData_u qData [`MAC_CMD_DEPTH];

    logic [PtrW-1:0]           wrPtr;
    logic [PtrW-1:0]           rdPtr;
    logic [PtrW:0]             qCount;
    logic [`MAC_ACC_COUNT-1:0] pending;
    logic [CredW-1:0]          resCnt;
    logic                      headReady;
    logic                      issueFire;
    logic                      readFire;

    // Head waits while its accumulator has an op in flight
    assign headReady = (qCount != '0) && !pending[qAcc[rdPtr]];
    // A READ also needs a result credit in hand
    assign issueFire = headReady && ((qOp[rdPtr] != READ) || (resCnt != '0));
    assign readFire  = issueFire && (qOp[rdPtr] == READ);

    assign issue.valid = issueFire;
    assign issue.op    = qOp[rdPtr];
    assign issue.acc   = qAcc[rdPtr];
    assign issue.data  = qData[rdPtr];

    // Queue storage, sender credits keep it from overflowing
    always_ff @(posedge clk) begin
        if (cmdValid) begin
            qOp[wrPtr]   <= cmdOp;
            qAcc[wrPtr]  <= cmdAcc;
            qData[wrPtr] <= cmdData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            qCount    <= '0;
            cmdCredit <= 1'b0;
        end else begin
            if (cmdValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (issueFire) begin
                rdPtr <= rdPtr + 1'b1;
            end
            qCount    <= qCount + (PtrW+1)'(cmdValid) - (PtrW+1)'(issueFire);
            // One credit back per command leaving the queue
            cmdCredit <= issueFire;
        end
    end

    // Scoreboard, one pending bit per accumulator
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (wb.valid) begin
                pending[wb.acc] <= 1'b0;
            end
            if (issueFire) begin
                pending[qAcc[rdPtr]] <= 1'b1;
            end
        end
    end

    // Credit is taken when a READ issues, so results never outrun credits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resCnt <= CredW'(`MAC_RES_CREDITS);
        end else begin
            case ({resCredit, readFire})
                2'b10:   resCnt <= resCnt + 1'b1;
                2'b01:   resCnt <= resCnt - 1'b1;
                default: resCnt <= resCnt;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fp16_add.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mac_consts.svh"

module fp16Add (
    input  mac_pkg::fp16_t x,
    input  mac_pkg::fp16_t y,
    output mac_pkg::fp16_t sum
);
    import mac_pkg::*;

    localparam int WideW = `FP16_MAN_BITS + 4;

    fp16_t big, smallOp;
    logic  xNan, xInf, yNan, yInf;
    logic  sumNan, anyInf, roundUp;
    logic [`FP16_EXP_BITS-1:0] bigExp, smallExp, expDiff;
    logic [WideW-1:0]          bigSig, smallSig, smallShift, smallAligned;
    logic                      alignSticky;
    logic [WideW:0]            rawSum;
    logic [4:0]                lz, shl;
    logic [WideW-1:0]          norm;
    logic [`FP16_EXP_BITS:0]   normExp, finalExp;
    logic [`FP16_MAN_BITS+1:0] rounded;
    logic [`FP16_MAN_BITS-1:0] finalMan;

    assign xNan   = (x.exp == `FP16_EXP_BITS'(`FP_EXP_MAX)) && (x.man != '0);
    assign xInf   = (x.exp == `FP16_EXP_BITS'(`FP_EXP_MAX)) && (x.man == '0);
    assign yNan   = (y.exp == `FP16_EXP_BITS'(`FP_EXP_MAX)) && (y.man != '0);
    assign yInf   = (y.exp == `FP16_EXP_BITS'(`FP_EXP_MAX)) && (y.man == '0);
    assign sumNan = xNan || yNan || (xInf && yInf && (x.sign != y.sign));
    assign anyInf = xInf || yInf;

    // Larger magnitude goes first and its sign wins
    assign big     = ({x.exp, x.man} >= {y.exp, y.man}) ? x : y;
    assign smallOp = ({x.exp, x.man} >= {y.exp, y.man}) ? y : x;

    assign bigExp   = (big.exp == '0) ? `FP16_EXP_BITS'(1) : big.exp;
    assign smallExp = (smallOp.exp == '0) ? `FP16_EXP_BITS'(1) : smallOp.exp;
    assign bigSig   = {big.exp != '0, big.man, 3'b000};
    assign smallSig = {smallOp.exp != '0, smallOp.man, 3'b000};
    assign expDiff  = bigExp - smallExp;

    // Bits shifted out of the smaller operand fold into sticky
    assign smallShift   = smallSig >> expDiff;
    assign alignSticky  = |(smallSig & ((WideW'(1) << expDiff) - WideW'(1)));
    assign smallAligned = {smallShift[WideW-1:1], smallShift[0] | alignSticky};

    assign rawSum = (big.sign == smallOp.sign) ? {1'b0, bigSig} + {1'b0, smallAligned} :
                                                 {1'b0, bigSig} - {1'b0, smallAligned};

    always_comb begin
        lz = 5'(WideW);
        for (int i = 0; i < WideW; i++) begin
            if (rawSum[i]) begin
                lz = 5'(WideW - 1 - i);
            end
        end
        if (rawSum[WideW]) begin
            // Carry out shifts one step right
            shl     = '0;
            norm    = {rawSum[WideW:2], rawSum[1] | rawSum[0]};
            normExp = (`FP16_EXP_BITS+1)'(bigExp) + 1'b1;
        end else begin
            // Left shift stops at the minimum exponent
            shl     = (lz > 5'(bigExp - 1'b1)) ? 5'(bigExp - 1'b1) : lz;
            norm    = rawSum[WideW-1:0] << shl;
            normExp = (`FP16_EXP_BITS+1)'(bigExp) - (`FP16_EXP_BITS+1)'(shl);
        end
    end

    assign roundUp = norm[2] && (norm[3] || norm[1] || norm[0]);
    assign rounded = {1'b0, norm[WideW-1:3]} + (`FP16_MAN_BITS+2)'(roundUp);

    // Renormalize after a rounding carry
    always_comb begin
        if (rounded[`FP16_MAN_BITS+1]) begin
            finalExp = normExp + 1'b1;
            finalMan = rounded[`FP16_MAN_BITS:1];
        end else begin
            // No hidden bit means subnormal
            finalExp = rounded[`FP16_MAN_BITS] ? normExp : '0;
            finalMan = rounded[`FP16_MAN_BITS-1:0];
        end
    end

    always_comb begin
        if (sumNan) begin
            sum = {big.sign, `FP16_EXP_BITS'(`FP_EXP_MAX), `FP16_MAN_BITS'(1)};
        end else if (anyInf || (finalExp >= (`FP16_EXP_BITS+1)'(`FP_EXP_MAX))) begin
            sum = {big.sign, `FP16_EXP_BITS'(`FP_EXP_MAX), `FP16_MAN_BITS'(0)};
        end else if (rounded == '0) begin
            // Exact cancellation gives +0 unless both were negative
            sum = {x.sign & y.sign, `FP16_EXP_BITS'(0), `FP16_MAN_BITS'(0)};
        end else begin
            sum = {big.sign, finalExp[`FP16_EXP_BITS-1:0], finalMan};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fp8_multiply.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mac_consts.svh"

module fp8Multiply (
    input  mac_pkg::fp8_t  a,
    input  mac_pkg::fp8_t  b,
    output mac_pkg::fp16_t product
);
    localparam int SigW   = `FP8_MAN_BITS + 1;
    localparam int ProdW  = 2 * SigW;
    // Hidden bit, mantissa, then guard, round and sticky
    localparam int WideW  = `FP16_MAN_BITS + 4;
    localparam int ExpAdj = `FP_EXP_BIAS + 2 * `FP8_MAN_BITS;
    localparam logic signed [7:0] ExpMaxS = 8'(`FP_EXP_MAX);

    logic aNan, aInf, aZero;
    logic bNan, bInf, bZero;
    logic [`FP8_EXP_BITS-1:0] aExpEff, bExpEff;
    logic [SigW-1:0]          aSig, bSig;
    logic [ProdW-1:0]         prod, prodNorm;
    logic [2:0]               lead;
    logic signed [7:0]        expSum;
    logic [3:0]               shAmt;
    logic [WideW-1:0]         wide, shifted;
    logic                     sticky, roundUp, sign;
    logic [`FP16_MAN_BITS:0]  rounded;
    logic [`FP16_EXP_BITS-1:0] expOut;

    assign aNan  = (a.exp == `FP8_EXP_BITS'(`FP_EXP_MAX)) && (a.man != '0);
    assign aInf  = (a.exp == `FP8_EXP_BITS'(`FP_EXP_MAX)) && (a.man == '0);
    assign aZero = (a.exp == '0) && (a.man == '0);
    assign bNan  = (b.exp == `FP8_EXP_BITS'(`FP_EXP_MAX)) && (b.man != '0);
    assign bInf  = (b.exp == `FP8_EXP_BITS'(`FP_EXP_MAX)) && (b.man == '0);
    assign bZero = (b.exp == '0) && (b.man == '0);

    // Subnormals take exponent 1 and no hidden bit
    assign aExpEff = (a.exp == '0) ? `FP8_EXP_BITS'(1) : a.exp;
    assign bExpEff = (b.exp == '0) ? `FP8_EXP_BITS'(1) : b.exp;
    assign aSig    = {a.exp != '0, a.man};
    assign bSig    = {b.exp != '0, b.man};
    assign prod    = aSig * bSig;
    assign sign    = a.sign ^ b.sign;

    always_comb begin
        lead = '0;
        for (int i = 0; i < ProdW; i++) begin
            if (prod[i]) begin
                lead = 3'(i);
            end
        end
    end

    // Leading one moved to the top, exponent follows its position
    assign prodNorm = prod << (ProdW - 1 - lead);
    assign expSum   = $signed(8'(aExpEff) + 8'(bExpEff) + 8'(lead) - 8'(ExpAdj));

    // Right shift into the subnormal range
    always_comb begin
        if (expSum > 8'sd0) begin
            shAmt = '0;
        end else if (expSum <= -8'sd13) begin
            shAmt = 4'(WideW);
        end else begin
            shAmt = 4'(8'sd1 - expSum);
        end
    end

    assign wide    = {prodNorm, {(WideW - ProdW){1'b0}}};
    assign shifted = wide >> shAmt;
    assign sticky  = |(wide & ((WideW'(1) << shAmt) - WideW'(1)));
    assign roundUp = shifted[2] && (shifted[3] || shifted[1] || shifted[0] || sticky);
    assign rounded = shifted[WideW-1:3] + (`FP16_MAN_BITS+1)'(roundUp);
    // A rounding carry out of a subnormal lands on exponent 1
    assign expOut  = (expSum > 8'sd0) ? expSum[`FP16_EXP_BITS-1:0] :
                     `FP16_EXP_BITS'(rounded[`FP16_MAN_BITS]);

    always_comb begin
        if (aNan || bNan || (aInf && bZero) || (aZero && bInf)) begin
            product = {sign, `FP16_EXP_BITS'(`FP_EXP_MAX), `FP16_MAN_BITS'(1)};
        end else if (aInf || bInf) begin
            product = {sign, `FP16_EXP_BITS'(`FP_EXP_MAX), `FP16_MAN_BITS'(0)};
        end else if (aZero || bZero) begin
            product = {sign, `FP16_EXP_BITS'(0), `FP16_MAN_BITS'(0)};
        end else if (expSum >= ExpMaxS) begin
            product = {sign, `FP16_EXP_BITS'(`FP_EXP_MAX), `FP16_MAN_BITS'(0)};
        end else begin
            product = {sign, expOut, rounded[`FP16_MAN_BITS-1:0]};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mac_cell_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module macCellTop (
    input  logic              clk,
    input  logic              rst_n,
    // Command port
    input  logic              cmdValid,
    input  mac_pkg::macOp_e   cmdOp,
    input  mac_pkg::accIdx_t  cmdAcc,
    input  mac_pkg::cmdData_u cmdData,
    output logic              cmdCredit,
    // Result port
    output logic              resValid,
    output mac_pkg::fp16_t    resData,
    input  logic              resCredit
);
    import mac_pkg::*;

    accIdx_t accSel;
    fp16_t   accValue;

    issueIf issueBus ();
    wbIf    wbBus ();

    cmdDecode uDecode (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmdValid (cmdValid),
        .cmdOp    (cmdOp),
        .cmdAcc   (cmdAcc),
        .cmdData  (cmdData),
        .resCredit(resCredit),
        .cmdCredit(cmdCredit),
        .issue    (issueBus.issue),
        .wb       (wbBus.monitor)
    );

    macExecute uExecute (
        .clk     (clk),
        .rst_n   (rst_n),
        .accValue(accValue),
        .accSel  (accSel),
        .issue   (issueBus.pipe),
        .wb      (wbBus.source)
    );

    accResult uResult (
        .clk     (clk),
        .rst_n   (rst_n),
        .accSel  (accSel),
        .accValue(accValue),
        .resValid(resValid),
        .resData (resData),
        .wb      (wbBus.sink)
    );

endmodule

`default_nettype wire

// ==== rtl/mac_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module macExecute (
    input  logic             clk,
    input  logic             rst_n,
    input  mac_pkg::fp16_t   accValue,
    output mac_pkg::accIdx_t accSel,
    issueIf.pipe             issue,
    wbIf.source              wb
);
    import mac_pkg::*;

    fp16_t   mulProd;
    fp16_t   addSum;
    logic    s1Valid;
    macOp_e  s1Op;
    accIdx_t s1Acc;
    fp16_t   s1Operand;
    fp16_t   s1AccVal;

    fp8Multiply uMul (
        .a      (issue.data.pair.a),
        .b      (issue.data.pair.b),
        .product(mulProd)
    );

    // Accumulator is read in the issue cycle
    assign accSel = issue.acc;

    // Stage one, product or load value next to the old accumulator
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Op      <= issue.op;
        s1Acc     <= issue.acc;
        s1Operand <= (issue.op == LOAD) ? issue.data.loadVal : mulProd;
        s1AccVal  <= accValue;
    end

    fp16Add uAdd (
        .x  (s1Operand),
        .y  (s1AccVal),
        .sum(addSum)
    );

    // Stage two drives writeback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        wb.op  <= s1Op;
        wb.acc <= s1Acc;
        case (s1Op)
            MAC:     wb.value <= addSum;
            LOAD:    wb.value <= s1Operand;
            default: wb.value <= s1AccVal;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mac_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

// Decode to execute, one item per valid cycle
interface issueIf;
    import mac_pkg::*;

    logic     valid;
    macOp_e   op;
    accIdx_t  acc;
    cmdData_u data;

    modport issue (output valid, op, acc, data);
    modport pipe  (input valid, op, acc, data);
endinterface

// Execute to result, decode watches it to release accumulators
interface wbIf;
    import mac_pkg::*;

    logic    valid;
    macOp_e  op;
    accIdx_t acc;
    fp16_t   value;

    modport source  (output valid, op, acc, value);
    modport sink    (input valid, op, acc, value);
    modport monitor (input valid, acc);
endinterface

`default_nettype wire

// ==== rtl/mac_pkg.sv ====
`default_nettype none

`include "mac_consts.svh"

package mac_pkg;

    typedef enum logic [1:0] {
        LOAD = 2'd0,
        MAC  = 2'd1,
        READ = 2'd2
    } macOp_e;

    typedef logic [`MAC_ACC_BITS-1:0] accIdx_t;

    typedef struct packed {
        logic                     sign;
        logic [`FP8_EXP_BITS-1:0] exp;
        logic [`FP8_MAN_BITS-1:0] man;
    } fp8_t;

    typedef struct packed {
        logic                      sign;
        logic [`FP16_EXP_BITS-1:0] exp;
        logic [`FP16_MAN_BITS-1:0] man;
    } fp16_t;

    typedef struct packed {
        fp8_t a;
        fp8_t b;
    } fp8Pair_t;

    // Command word, a load value for LOAD or two operands for MAC
    typedef union packed {
        fp16_t    loadVal;
        fp8Pair_t pair;
    } cmdData_u;

endpackage

`default_nettype wire

// ==== sim/mac_cases.txt ====
// Columns: op (0 LOAD, 1 MAC, 2 READ) _ accumulator _ data word _ expected READ value
// MAC data holds operand a in the upper byte and operand b in the lower byte
0_0_3c00_0000
0_1_c500_0000
0_2_0001_0000
0_3_7bff_0000
2_0_0000_3c00
2_1_0000_c500
2_2_0000_0001
2_3_0000_7bff
1_0_3e42_0000
1_1_8404_0000
1_0_0374_0000
1_2_1112_0000
1_0_3e18_0000
1_3_783f_0000
2_0_0000_4641
2_1_0000_c500
2_2_0000_0009
2_3_0000_7c00
1_2_7c00_0000
1_1_7ebc_0000
2_2_0000_7c01
2_1_0000_fc01

// ==== sim/tb_mac_cell.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mac_consts.svh"

module tbMacCell;
    import mac_pkg::*;

    localparam int          ClkPeriod   = 10;
    localparam int          MaxCases    = 64;
    localparam int          WatchCycles = 200;
    localparam logic [15:0] LfsrTaps    = 16'hB400;

    logic     clk;
    logic     rst_n;
    logic     cmdValid;
    macOp_e   cmdOp;
    accIdx_t  cmdAcc;
    cmdData_u cmdData;
    logic     cmdCredit;
    logic     resValid;
    fp16_t    resData;
    logic     resCredit;

    // One case per word with op, accumulator, data and expected value
    logic [39:0] caseMem [MaxCases];
    int          numCases;
    fp16_t       expected [$];
    logic [15:0] lfsr;

    int senderCredits;
    int cellCredits;
    int creditOwed;
    int holdCycles;
    int sentCount;
    int creditPulses;

    macCellTop UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmdValid (cmdValid),
        .cmdOp    (cmdOp),
        .cmdAcc   (cmdAcc),
        .cmdData  (cmdData),
        .cmdCredit(cmdCredit),
        .resValid (resValid),
        .resData  (resData),
        .resCredit(resCredit)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkFp16(input string sigName, input fp16_t expVal, input fp16_t actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("ERR %0t %s expected %h actual %h",
                              $time, sigName, expVal, actVal));
        end
    endtask

    task automatic checkCount(input string sigName, input int expVal, input int actVal);
        if (actVal != expVal) begin
            failRun($sformatf("ERR %0t %s expected %0d actual %0d",
                              $time, sigName, expVal, actVal));
        end
    endtask

    // Galois LFSR stepped once per bit handed out
    function automatic int randomBits(input int n);
        int   value;
        logic outBit;
        value = 0;
        for (int i = 0; i < n; i++) begin
            outBit = lfsr[0];
            lfsr   = (lfsr >> 1) ^ (outBit ? LfsrTaps : 16'h0000);
            value  = (value << 1) | int'(outBit);
        end
        return value;
    endfunction

    function automatic int creditDelay();
        int delay;
        if (randomBits(2) == 0) begin
            // Long stretch with result credits withheld
            delay = 24 + randomBits(5);
        end else begin
            delay = randomBits(3);
        end
        return delay;
    endfunction

    task automatic loadCases();
        for (int i = 0; i < MaxCases; i++) begin
            caseMem[i] = '1;
        end
        $readmemh("sim/mac_cases.txt", caseMem);
        numCases = 0;
        // Op nibble F marks the first unused word
        while (numCases < MaxCases && caseMem[numCases][39:36] != 4'hF) begin
            numCases++;
        end
        if (numCases == 0) begin
            failRun("No cases could be read from sim/mac_cases.txt");
        end
    endtask

    task automatic sampleOutputs();
        if (cmdCredit) begin
            creditPulses++;
            senderCredits++;
            if (senderCredits > `MAC_CMD_DEPTH) begin
                failRun("The cell returned more command credits than the queue holds");
            end
        end
        if (resValid) begin
            if (expected.size() == 0) begin
                failRun("A result arrived with no expected value pending");
            end else if (cellCredits == 0) begin
                failRun("A result arrived while the cell held no result credit");
            end else begin
                checkFp16("resData", expected.pop_front(), resData);
                cellCredits--;
                if (creditOwed == 0) begin
                    holdCycles = creditDelay();
                end
                creditOwed++;
            end
        end
    endtask

    task automatic driveResultCredit();
        resCredit = 1'b0;
        if (creditOwed > 0) begin
            if (holdCycles > 0) begin
                holdCycles--;
            end else begin
                resCredit   = 1'b1;
                creditOwed--;
                cellCredits++;
                holdCycles  = creditDelay();
            end
        end
    endtask

    task automatic driveCommand();
        logic [39:0] word;
        cmdValid = 1'b0;
        if (sentCount < numCases && senderCredits > 0) begin
            word     = caseMem[sentCount];
            cmdValid = 1'b1;
            cmdOp    = macOp_e'(word[37:36]);
            cmdAcc   = word[33:32];
            cmdData  = cmdData_u'(word[31:16]);
            if (cmdOp == READ) begin
                expected.push_back(fp16_t'(word[15:0]));
            end
            senderCredits--;
            sentCount++;
        end
    endtask

    // Watchdog sized by the number of case lines
    initial begin
        wait (numCases > 0);
        repeat (numCases * WatchCycles) @(posedge clk);
        failRun("Timeout, the cell did not finish the cases in time");
    end

    initial begin
        rst_n         = 1'b0;
        cmdValid      = 1'b0;
        cmdOp         = LOAD;
        cmdAcc        = '0;
        cmdData       = '0;
        resCredit     = 1'b0;
        lfsr          = 16'd94;
        senderCredits = `MAC_CMD_DEPTH;
        cellCredits   = `MAC_RES_CREDITS;
        creditOwed    = 0;
        holdCycles    = 0;
        sentCount     = 0;
        creditPulses  = 0;
        numCases      = 0;
        loadCases();

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Outputs are sampled before new inputs go out on the falling edge
        while (!(sentCount == numCases && expected.size() == 0 && creditOwed == 0)) begin
            @(negedge clk);
            sampleOutputs();
            driveResultCredit();
            driveCommand();
        end

        checkCount("cmdCredit pulses", sentCount, creditPulses);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
